// File: pr_defs.svh
`ifndef PR_DEFS_SVH
`define PR_DEFS_SVH

// DMA side
`define PR_DATA_WIDTH 128
`define PR_STRB_WIDTH 16
`define PR_ADDR_WIDTH 26

// Packet memory, broadcast region is the top PR_BC_LINES lines
`define PR_PMEM_LINES 256
`define PR_BC_LINES 32
`define PR_BC_ADDR_WIDTH 7

`define PR_STATUS_ADDR_WIDTH 3

// Stages per boundary slice
`define PR_REG_LENGTH 1

`endif

// File: pr_pkg.sv
`include "pr_defs.svh"

package pr_pkg;

  typedef enum logic [3:0] {
    DESC_FWD   = 4'd0,
    DESC_DUP   = 4'd1,
    DESC_BCAST = 4'd2,
    DESC_DROP  = 4'd3
  } desc_op_t;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_OUT1,
    ENG_OUT2,
    ENG_BC
  } eng_state_t;

  typedef struct packed {
    logic [`PR_DATA_WIDTH-1:0] data;
    logic [`PR_ADDR_WIDTH-1:0] addr;
    logic [`PR_STRB_WIDTH-1:0] strb;
    logic                      last;
  } dma_wr_t;

  typedef struct packed {
    logic [`PR_ADDR_WIDTH-1:0] addr;
    logic                      last;
  } dma_rd_t;

  typedef struct packed {
    desc_op_t                     op;
    logic [7:0]                   tag;
    logic [`PR_BC_ADDR_WIDTH-1:0] bc_addr;
    logic [3:0]                   bc_strb;
    logic [2:0]                   core_id;
    logic [5:0]                   spare;
    logic [31:0]                  payload;
  } desc_t;

  typedef struct packed {
    logic  second;
    desc_t desc;
  } out_desc_t;

  typedef struct packed {
    logic [31:0]                  data;
    logic [3:0]                   strb;
    logic [`PR_BC_ADDR_WIDTH-1:0] addr;
  } bc_msg_t;

  typedef struct packed {
    logic [`PR_STATUS_ADDR_WIDTH-1:0] addr;
    logic [31:0]                      data;
  } status_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_LENGTH = 1
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [DATA_WIDTH-1:0] s_data,
  input  logic                  s_valid,
  output logic                  s_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic                  m_valid,
  input  logic                  m_ready
);

  // Link i feeds stage i, last link is the output side
  logic [DATA_WIDTH-1:0] link_data [REG_LENGTH+1];
  logic [REG_LENGTH:0]   link_valid;
  logic [REG_LENGTH:0]   link_ready;

  assign link_data[0]  = s_data;
  assign link_valid[0] = s_valid;
  assign s_ready       = link_ready[0];

  assign m_data                 = link_data[REG_LENGTH];
  assign m_valid                = link_valid[REG_LENGTH];
  assign link_ready[REG_LENGTH] = m_ready;

  for (genvar i = 0; i < REG_LENGTH; i++) begin : g_stage
    logic [DATA_WIDTH-1:0] main_data;
    logic [DATA_WIDTH-1:0] spare_data;
    logic                  main_valid;
    logic                  spare_valid;
    logic                  take;
    logic                  advance;

    // Ready comes straight from a flop, spare absorbs the item in flight
    assign link_ready[i] = !spare_valid;
    assign take          = link_valid[i] && !spare_valid;
    assign advance       = !main_valid || link_ready[i+1];

    always_ff @(posedge clk) begin
      if (reset) begin
        main_valid  <= 1'b0;
        spare_valid <= 1'b0;
      end else if (advance) begin
        main_valid  <= spare_valid || take;
        spare_valid <= 1'b0;
      end else if (take) begin
        spare_valid <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (advance) begin
        main_data <= spare_valid ? spare_data : link_data[i];
      end else if (take) begin
        spare_data <= link_data[i];
      end
    end

    assign link_data[i+1]  = main_data;
    assign link_valid[i+1] = main_valid;
  end

endmodule

// File: pkt_mem.sv
`timescale 1ns/100ps
`include "pr_defs.svh"

module pkt_mem (
  input  logic                      clk,
  input  logic                      reset,
  input  pr_pkg::dma_wr_t           wr,
  input  logic                      wr_valid,
  output logic                      wr_ready,
  input  pr_pkg::bc_msg_t           bc,
  input  logic                      bc_valid,
  input  pr_pkg::dma_rd_t           rd,
  input  logic                      rd_valid,
  output logic                      rd_ready,
  output logic [`PR_DATA_WIDTH-1:0] resp_data,
  output logic                      resp_valid,
  input  logic                      resp_ready
);

  localparam int LINE_W = $clog2(`PR_PMEM_LINES);
  localparam logic [LINE_W-1:0] BC_BASE = LINE_W'(`PR_PMEM_LINES - `PR_BC_LINES);

  logic [`PR_DATA_WIDTH-1:0] mem [`PR_PMEM_LINES];
  logic [LINE_W-1:0]         wr_line;
  logic [LINE_W-1:0]         rd_line;
  logic [LINE_W-1:0]         bc_line;

  assign wr_line = wr.addr[LINE_W+3:4];
  assign rd_line = rd.addr[LINE_W+3:4];
  assign bc_line = BC_BASE + LINE_W'(bc.addr[`PR_BC_ADDR_WIDTH-1:2]);

  // Broadcast writes win the write port
  assign wr_ready = !bc_valid;

  always_ff @(posedge clk) begin
    if (bc_valid) begin
      for (int b = 0; b < 4; b++) begin
        if (bc.strb[b]) begin
          mem[bc_line][bc.addr[1:0]*32 + b*8 +: 8] <= bc.data[b*8 +: 8];
        end
      end
    end else if (wr_valid) begin
      for (int b = 0; b < `PR_STRB_WIDTH; b++) begin
        if (wr.strb[b]) begin
          mem[wr_line][b*8 +: 8] <= wr.data[b*8 +: 8];
        end
      end
    end
  end

  // One-entry response, refilled as it drains
  assign rd_ready = !resp_valid || resp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else if (rd_ready) begin
      resp_valid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid && rd_ready) begin
      resp_data <= mem[rd_line];
    end
  end

endmodule

// File: desc_engine.sv
`timescale 1ns/100ps

module desc_engine (
  input  logic              clk,
  input  logic              reset,
  input  pr_pkg::desc_t     in_desc,
  input  logic              in_valid,
  output logic              in_taken,
  input  logic [2:0]        core_id,
  output pr_pkg::out_desc_t out_desc,
  output logic              out_valid,
  input  logic              out_ready,
  output pr_pkg::bc_msg_t   bc_out,
  output logic              bc_valid,
  input  logic              bc_ready,
  output logic              desc_done,
  output logic              bc_sent
);

  import pr_pkg::*;

  eng_state_t state;
  eng_state_t state_next;
  desc_t      cur;
  logic       release_desc;

  assign in_taken = (state == ENG_IDLE);

  always_comb begin
    state_next   = state;
    release_desc = 1'b0;
    case (state)
      ENG_IDLE: begin
        if (in_valid) begin
          case (in_desc.op)
            DESC_FWD, DESC_DUP: state_next = ENG_OUT1;
            DESC_BCAST:         state_next = ENG_BC;
            // Drop and unknown codes finish right away
            default:            release_desc = 1'b1;
          endcase
        end
      end
      ENG_OUT1: begin
        if (out_ready) begin
          if (cur.op == DESC_DUP) begin
            state_next = ENG_OUT2;
          end else begin
            state_next   = ENG_IDLE;
            release_desc = 1'b1;
          end
        end
      end
      ENG_OUT2, ENG_BC: begin
        if ((state == ENG_OUT2) ? out_ready : bc_ready) begin
          state_next   = ENG_IDLE;
          release_desc = 1'b1;
        end
      end
      default: state_next = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ENG_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_taken) begin
      cur         <= in_desc;
      cur.core_id <= core_id;
    end
  end

  always_comb begin
    out_desc.desc   = cur;
    out_desc.second = (state == ENG_OUT2);
    bc_out.data     = cur.payload;
    bc_out.strb     = cur.bc_strb;
    bc_out.addr     = cur.bc_addr;
  end

  assign out_valid = (state == ENG_OUT1) || (state == ENG_OUT2);
  assign bc_valid  = (state == ENG_BC);
  assign bc_sent   = bc_valid && bc_ready;
  assign desc_done = release_desc;

endmodule

// File: status_unit.sv
`timescale 1ns/100ps
`include "pr_defs.svh"

module status_unit (
  input  logic            clk,
  input  logic            reset,
  input  pr_pkg::status_t wr_status,
  output pr_pkg::status_t rd_status,
  output logic [2:0]      core_id,
  input  logic            desc_done,
  input  logic            bc_sent,
  input  logic            bc_rcvd
);

  logic [31:0]                      words [2**`PR_STATUS_ADDR_WIDTH];
  logic [31:0]                      done_cnt;
  logic [31:0]                      sent_cnt;
  logic [31:0]                      rcvd_cnt;
  logic [`PR_STATUS_ADDR_WIDTH-1:0] rpt_addr;

  always_ff @(posedge clk) begin
    words[wr_status.addr] <= wr_status.data;
  end

  assign core_id = words[0][2:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      done_cnt <= '0;
      sent_cnt <= '0;
      rcvd_cnt <= '0;
      rpt_addr <= '0;
    end else begin
      done_cnt <= done_cnt + desc_done;
      sent_cnt <= sent_cnt + bc_sent;
      rcvd_cnt <= rcvd_cnt + bc_rcvd;
      rpt_addr <= (rpt_addr == 2) ? '0 : rpt_addr + 1'b1;
    end
  end

  // Counters report on addresses 0 to 2 in turn
  always_comb begin
    rd_status.addr = rpt_addr;
    case (rpt_addr)
      0:       rd_status.data = done_cnt;
      1:       rd_status.data = sent_cnt;
      default: rd_status.data = rcvd_cnt;
    endcase
  end

endmodule

// File: pr_core.sv
`timescale 1ns/100ps
`include "pr_defs.svh"

module pr_core (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      core_reset,
  input  pr_pkg::dma_wr_t           dma_wr,
  input  logic                      dma_wr_valid,
  output logic                      dma_wr_ready,
  input  pr_pkg::dma_rd_t           dma_rd,
  input  logic                      dma_rd_valid,
  output logic                      dma_rd_ready,
  output logic [`PR_DATA_WIDTH-1:0] dma_rd_resp_data,
  output logic                      dma_rd_resp_valid,
  input  logic                      dma_rd_resp_ready,
  input  pr_pkg::desc_t             in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,
  output pr_pkg::out_desc_t         out_desc,
  output logic                      out_desc_valid,
  input  logic                      out_desc_ready,
  input  pr_pkg::bc_msg_t           bc_msg_in,
  input  logic                      bc_msg_in_valid,
  output pr_pkg::bc_msg_t           bc_msg_out,
  output logic                      bc_msg_out_valid,
  input  logic                      bc_msg_out_ready,
  input  pr_pkg::status_t           wrapper_status,
  output pr_pkg::status_t           core_status
);

  logic       core_rst;
  logic [2:0] core_id;
  logic       desc_done;
  logic       bc_sent;

  // Core reset restarts the engine and counters, memory keeps its data
  assign core_rst = reset | core_reset;

  // Write ready drops while a broadcast-in message owns the memory
  pkt_mem pkt_mem_inst (
    .clk(clk), .reset(reset),
    .wr(dma_wr), .wr_valid(dma_wr_valid), .wr_ready(dma_wr_ready),
    .bc(bc_msg_in), .bc_valid(bc_msg_in_valid),
    .rd(dma_rd), .rd_valid(dma_rd_valid), .rd_ready(dma_rd_ready),
    .resp_data(dma_rd_resp_data), .resp_valid(dma_rd_resp_valid),
    .resp_ready(dma_rd_resp_ready)
  );

  desc_engine desc_engine_inst (
    .clk(clk), .reset(core_rst),
    .in_desc(in_desc), .in_valid(in_desc_valid), .in_taken(in_desc_taken),
    .core_id(core_id),
    .out_desc(out_desc), .out_valid(out_desc_valid), .out_ready(out_desc_ready),
    .bc_out(bc_msg_out), .bc_valid(bc_msg_out_valid), .bc_ready(bc_msg_out_ready),
    .desc_done(desc_done), .bc_sent(bc_sent)
  );

  status_unit status_unit_inst (
    .clk(clk), .reset(core_rst),
    .wr_status(wrapper_status), .rd_status(core_status),
    .core_id(core_id),
    .desc_done(desc_done), .bc_sent(bc_sent), .bc_rcvd(bc_msg_in_valid)
  );

endmodule

// File: pr_wrapper.sv
`timescale 1ns/100ps
`include "pr_defs.svh"

module pr_wrapper (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      core_reset,
  input  pr_pkg::dma_wr_t           dma_wr,
  input  logic                      dma_wr_valid,
  output logic                      dma_wr_ready,
  input  pr_pkg::dma_rd_t           dma_rd,
  input  logic                      dma_rd_valid,
  output logic                      dma_rd_ready,
  output logic [`PR_DATA_WIDTH-1:0] dma_rd_resp_data,
  output logic                      dma_rd_resp_valid,
  input  logic                      dma_rd_resp_ready,
  input  pr_pkg::desc_t             in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,
  output pr_pkg::out_desc_t         out_desc,
  output logic                      out_desc_valid,
  input  logic                      out_desc_ready,
  input  pr_pkg::bc_msg_t           bc_msg_in,
  input  logic                      bc_msg_in_valid,
  output pr_pkg::bc_msg_t           bc_msg_out,
  output logic                      bc_msg_out_valid,
  input  logic                      bc_msg_out_ready,
  input  pr_pkg::status_t           wrapper_status,
  output pr_pkg::status_t           core_status
);

  import pr_pkg::*;

  localparam int RL = `PR_REG_LENGTH;

  //////////////////////////////////////////////////////////////////////
  // Resets and status buses
  //////////////////////////////////////////////////////////////////////
  logic    reset_r;
  logic    core_reset_r;
  logic    desc_reset;
  status_t wrapper_status_r;
  status_t core_status_n;

  always_ff @(posedge clk) begin
    reset_r      <= reset;
    core_reset_r <= core_reset;
  end

  assign desc_reset = reset_r | core_reset_r;

  always_ff @(posedge clk) begin
    wrapper_status_r <= wrapper_status;
    core_status      <= core_status_n;
  end

  //////////////////////////////////////////////////////////////////////
  // Channel slices
  //////////////////////////////////////////////////////////////////////
  dma_wr_t                   dma_wr_r;
  logic                      dma_wr_valid_r;
  logic                      dma_wr_ready_r;
  dma_rd_t                   dma_rd_r;
  logic                      dma_rd_valid_r;
  logic                      dma_rd_ready_r;
  logic [`PR_DATA_WIDTH-1:0] resp_data_n;
  logic                      resp_valid_n;
  logic                      resp_ready_n;
  desc_t                     in_desc_r;
  logic                      in_desc_valid_r;
  logic                      in_desc_taken_r;
  out_desc_t                 out_desc_n;
  logic                      out_desc_valid_n;
  logic                      out_desc_ready_n;
  bc_msg_t                   bc_msg_in_r;
  logic                      bc_msg_in_valid_r;
  bc_msg_t                   bc_msg_out_n;
  logic                      bc_msg_out_valid_n;
  logic                      bc_msg_out_ready_n;

  pipe_reg #(.DATA_WIDTH($bits(dma_wr_t)), .REG_LENGTH(RL)) dma_wr_reg (
    .clk(clk), .reset(reset_r),
    .s_data(dma_wr), .s_valid(dma_wr_valid), .s_ready(dma_wr_ready),
    .m_data(dma_wr_r), .m_valid(dma_wr_valid_r), .m_ready(dma_wr_ready_r)
  );

  pipe_reg #(.DATA_WIDTH($bits(dma_rd_t)), .REG_LENGTH(RL)) dma_rd_reg (
    .clk(clk), .reset(reset_r),
    .s_data(dma_rd), .s_valid(dma_rd_valid), .s_ready(dma_rd_ready),
    .m_data(dma_rd_r), .m_valid(dma_rd_valid_r), .m_ready(dma_rd_ready_r)
  );

  pipe_reg #(.DATA_WIDTH(`PR_DATA_WIDTH), .REG_LENGTH(RL)) dma_rd_resp_reg (
    .clk(clk), .reset(reset_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid), .m_ready(dma_rd_resp_ready)
  );

  pipe_reg #(.DATA_WIDTH($bits(desc_t)), .REG_LENGTH(RL)) in_desc_reg (
    .clk(clk), .reset(desc_reset),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_taken_r)
  );

  pipe_reg #(.DATA_WIDTH($bits(out_desc_t)), .REG_LENGTH(RL)) out_desc_reg (
    .clk(clk), .reset(desc_reset),
    .s_data(out_desc_n), .s_valid(out_desc_valid_n), .s_ready(out_desc_ready_n),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  // Broadcast-in has no back-pressure
  pipe_reg #(.DATA_WIDTH($bits(bc_msg_t)), .REG_LENGTH(RL)) bc_msg_in_reg (
    .clk(clk), .reset(desc_reset),
    .s_data(bc_msg_in), .s_valid(bc_msg_in_valid), .s_ready(),
    .m_data(bc_msg_in_r), .m_valid(bc_msg_in_valid_r), .m_ready(1'b1)
  );

  pipe_reg #(.DATA_WIDTH($bits(bc_msg_t)), .REG_LENGTH(RL)) bc_msg_out_reg (
    .clk(clk), .reset(reset_r),
    .s_data(bc_msg_out_n), .s_valid(bc_msg_out_valid_n), .s_ready(bc_msg_out_ready_n),
    .m_data(bc_msg_out), .m_valid(bc_msg_out_valid), .m_ready(bc_msg_out_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Core
  //////////////////////////////////////////////////////////////////////
  pr_core pr_core_inst (
    .clk(clk), .reset(reset_r), .core_reset(core_reset_r),
    .dma_wr(dma_wr_r), .dma_wr_valid(dma_wr_valid_r), .dma_wr_ready(dma_wr_ready_r),
    .dma_rd(dma_rd_r), .dma_rd_valid(dma_rd_valid_r), .dma_rd_ready(dma_rd_ready_r),
    .dma_rd_resp_data(resp_data_n), .dma_rd_resp_valid(resp_valid_n),
    .dma_rd_resp_ready(resp_ready_n),
    .in_desc(in_desc_r), .in_desc_valid(in_desc_valid_r), .in_desc_taken(in_desc_taken_r),
    .out_desc(out_desc_n), .out_desc_valid(out_desc_valid_n),
    .out_desc_ready(out_desc_ready_n),
    .bc_msg_in(bc_msg_in_r), .bc_msg_in_valid(bc_msg_in_valid_r),
    .bc_msg_out(bc_msg_out_n), .bc_msg_out_valid(bc_msg_out_valid_n),
    .bc_msg_out_ready(bc_msg_out_ready_n),
    .wrapper_status(wrapper_status_r), .core_status(core_status_n)
  );

endmodule

// File: pr_wrapper_chk.sv
`timescale 1ns/100ps
`include "pr_defs.svh"

module pr_wrapper_chk (
  input logic                      clk,
  input logic                      reset,
  input pr_pkg::out_desc_t         out_desc,
  input logic                      out_desc_valid,
  input logic                      out_desc_ready,
  input pr_pkg::bc_msg_t           bc_msg_out,
  input logic                      bc_msg_out_valid,
  input logic                      bc_msg_out_ready,
  input logic [`PR_DATA_WIDTH-1:0] dma_rd_resp_data,
  input logic                      dma_rd_resp_valid,
  input logic                      dma_rd_resp_ready,
  input pr_pkg::status_t           core_status
);

  int fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Output channels hold under back-pressure
  //////////////////////////////////////////////////////////////////////
  a_out_desc_hold: assert property (@(posedge clk) disable iff (reset)
    out_desc_valid && !out_desc_ready |=> out_desc_valid && $stable(out_desc))
  else begin
    $error("out_desc changed while stalled");
    fail_cnt++;
  end

  a_bc_out_hold: assert property (@(posedge clk) disable iff (reset)
    bc_msg_out_valid && !bc_msg_out_ready |=> bc_msg_out_valid && $stable(bc_msg_out))
  else begin
    $error("bc_msg_out changed while stalled");
    fail_cnt++;
  end

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    dma_rd_resp_valid && !dma_rd_resp_ready |=> dma_rd_resp_valid
      && $stable(dma_rd_resp_data))
  else begin
    $error("dma_rd_resp changed while stalled");
    fail_cnt++;
  end

  // Only counter addresses are reported
  a_status_addr: assert property (@(posedge clk) disable iff (reset)
    core_status.addr <= 2)
  else begin
    $error("core_status addr out of range");
    fail_cnt++;
  end

  a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !out_desc_valid)
  else begin
    $error("out_desc_valid high after reset");
    fail_cnt++;
  end

endmodule

bind pr_wrapper pr_wrapper_chk chk_inst (.*);

// File: tb_pr_wrapper.sv
`timescale 1ns/100ps
`include "pr_defs.svh"

module tb_pr_wrapper;

  import pr_pkg::*;

  typedef enum logic [2:0] {T_WR, T_RD, T_WRBC, T_BC, T_DESC, T_CRST, T_STAT} kind_t;

  typedef struct packed {
    kind_t                     kind;
    logic [`PR_ADDR_WIDTH-1:0] addr;
    logic [`PR_STRB_WIDTH-1:0] strb;
    desc_t                     desc;
  } entry_t;

  // Word 0 of the wrapper status, low bits are the core id
  localparam logic [31:0] STATUS_WORD0 = 32'h5a5a_0c05;
  localparam logic [2:0]  CORE_ID      = STATUS_WORD0[2:0];

  logic                      clk;
  logic                      reset;
  logic                      core_reset;
  dma_wr_t                   dma_wr;
  logic                      dma_wr_valid;
  logic                      dma_wr_ready;
  dma_rd_t                   dma_rd;
  logic                      dma_rd_valid;
  logic                      dma_rd_ready;
  logic [`PR_DATA_WIDTH-1:0] dma_rd_resp_data;
  logic                      dma_rd_resp_valid;
  logic                      dma_rd_resp_ready;
  desc_t                     in_desc;
  logic                      in_desc_valid;
  logic                      in_desc_taken;
  out_desc_t                 out_desc;
  logic                      out_desc_valid;
  logic                      out_desc_ready;
  bc_msg_t                   bc_msg_in;
  logic                      bc_msg_in_valid;
  bc_msg_t                   bc_msg_out;
  logic                      bc_msg_out_valid;
  logic                      bc_msg_out_ready;
  status_t                   wrapper_status;
  status_t                   core_status;

  logic [`PR_DATA_WIDTH-1:0] model_mem [`PR_PMEM_LINES];
  logic [`PR_DATA_WIDTH-1:0] exp_resp [$];
  out_desc_t                 exp_desc [$];
  bc_msg_t                   exp_bc [$];
  entry_t                    tests [$];
  int                        errors = 0;
  int                        n_checks = 0;
  int                        cnt_done = 0;
  int                        cnt_sent = 0;
  int                        cnt_rcvd = 0;
  int                        cycles = 0;
  int                        limit = 0;

  pr_wrapper i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitors and random back-pressure
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (out_desc_valid && out_desc_ready) begin
      if (exp_desc.size() == 0) begin
        errors++;
        $display("An out descriptor arrived at %0t when none was expected", $time);
      end else begin
        check_value("out_desc", out_desc, exp_desc.pop_front());
      end
    end
    if (bc_msg_out_valid && bc_msg_out_ready) begin
      if (exp_bc.size() == 0) begin
        errors++;
        $display("A broadcast message arrived at %0t when none was expected", $time);
      end else begin
        check_value("bc_msg_out", bc_msg_out, exp_bc.pop_front());
      end
    end
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      if (exp_resp.size() == 0) begin
        errors++;
        $display("A read response arrived at %0t with no read pending", $time);
      end else begin
        check_value("dma_rd_resp_data", dma_rd_resp_data, exp_resp.pop_front());
      end
    end
    if (!reset) begin
      out_desc_ready    <= ($urandom() % 2) == 1;
      bc_msg_out_ready  <= ($urandom() % 2) == 1;
      dma_rd_resp_ready <= ($urandom() % 2) == 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("The run hung and was stopped after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model and stimulus tasks
  //////////////////////////////////////////////////////////////////////
  function automatic void model_bc(input bc_msg_t m);
    int line;
    int lane;
    line = `PR_PMEM_LINES - `PR_BC_LINES + m.addr[6:2];
    lane = m.addr[1:0];
    for (int b = 0; b < 4; b++) begin
      if (m.strb[b]) begin
        model_mem[line][lane*32 + b*8 +: 8] = m.data[b*8 +: 8];
      end
    end
  endfunction

  task automatic dma_write(input entry_t e, input bit with_bc);
    dma_wr_t w;
    bc_msg_t m;
    w.data = {$urandom(), $urandom(), $urandom(), $urandom()};
    w.addr = e.addr;
    w.strb = e.strb;
    w.last = 1'b1;
    for (int b = 0; b < `PR_STRB_WIDTH; b++) begin
      if (w.strb[b]) begin
        model_mem[e.addr[11:4]][b*8 +: 8] = w.data[b*8 +: 8];
      end
    end
    dma_wr       <= w;
    dma_wr_valid <= 1'b1;
    if (with_bc) begin
      m.data = $urandom();
      m.strb = e.desc.bc_strb;
      m.addr = e.desc.bc_addr;
      model_bc(m);
      cnt_rcvd++;
      bc_msg_in       <= m;
      bc_msg_in_valid <= 1'b1;
    end
    @(posedge clk);
    bc_msg_in_valid <= 1'b0;
    while (!dma_wr_ready) @(posedge clk);
    dma_wr_valid <= 1'b0;
  endtask

  task automatic send_bc(input desc_t d);
    bc_msg_t m;
    m.data = $urandom();
    m.strb = d.bc_strb;
    m.addr = d.bc_addr;
    model_bc(m);
    cnt_rcvd++;
    bc_msg_in       <= m;
    bc_msg_in_valid <= 1'b1;
    @(posedge clk);
    bc_msg_in_valid <= 1'b0;
  endtask

  task automatic dma_read(input logic [`PR_ADDR_WIDTH-1:0] addr);
    dma_rd_t r;
    r.addr = addr;
    r.last = 1'b1;
    exp_resp.push_back(model_mem[addr[11:4]]);
    dma_rd       <= r;
    dma_rd_valid <= 1'b1;
    @(posedge clk);
    while (!dma_rd_ready) @(posedge clk);
    dma_rd_valid <= 1'b0;
    while (exp_resp.size() != 0) @(posedge clk);
  endtask

  task automatic send_desc(input desc_t d);
    out_desc_t o;
    bc_msg_t   m;
    o.desc         = d;
    o.desc.core_id = CORE_ID;
    o.second       = 1'b0;
    case (d.op)
      DESC_FWD: exp_desc.push_back(o);
      DESC_DUP: begin
        exp_desc.push_back(o);
        o.second = 1'b1;
        exp_desc.push_back(o);
      end
      DESC_BCAST: begin
        m.data = d.payload;
        m.strb = d.bc_strb;
        m.addr = d.bc_addr;
        exp_bc.push_back(m);
        cnt_sent++;
      end
      default: ;
    endcase
    cnt_done++;
    in_desc       <= d;
    in_desc_valid <= 1'b1;
    @(posedge clk);
    while (!in_desc_taken) @(posedge clk);
    in_desc_valid <= 1'b0;
    while (exp_desc.size() != 0 || exp_bc.size() != 0) @(posedge clk);
  endtask

  task automatic pulse_core_reset();
    core_reset <= 1'b1;
    repeat (2) @(posedge clk);
    core_reset <= 1'b0;
    cnt_done = 0;
    cnt_sent = 0;
    cnt_rcvd = 0;
  endtask

  // Counters rotate over addresses 0 to 2
  task automatic check_status();
    logic [2:0] seen;
    seen = '0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      case (core_status.addr)
        3'd0:    check_value("core_status done count", core_status.data, cnt_done);
        3'd1:    check_value("core_status sent count", core_status.data, cnt_sent);
        3'd2:    check_value("core_status rcvd count", core_status.data, cnt_rcvd);
        default: check_value("core_status.addr", core_status.addr, 3'd2);
      endcase
      if (core_status.addr <= 3'd2) begin
        seen[core_status.addr] = 1'b1;
      end
    end
    if (seen != 3'b111) begin
      errors++;
      $display("core_status skipped a counter address in three cycles at %0t", $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////////////////////////
  function automatic desc_t mk_desc(input logic [3:0] op, input logic [7:0] tag,
                                    input logic [6:0] bc_addr, input logic [3:0] bc_strb,
                                    input logic [31:0] payload);
    desc_t d;
    d         = '0;
    d.op      = desc_op_t'(op);
    d.tag     = tag;
    d.bc_addr = bc_addr;
    d.bc_strb = bc_strb;
    d.core_id = 3'd7;
    d.spare   = 6'h2a;
    d.payload = payload;
    return d;
  endfunction

  function automatic void add_test(input kind_t k, input logic [25:0] a,
                                   input logic [15:0] s, input desc_t d);
    entry_t e;
    e.kind = k;
    e.addr = a;
    e.strb = s;
    e.desc = d;
    tests.push_back(e);
  endfunction

  function automatic void build_tests();
    add_test(T_WR,   26'h000, 16'hffff, '0);
    add_test(T_WR,   26'h010, 16'hffff, '0);
    add_test(T_WR,   26'h000, 16'h00f0, '0);
    add_test(T_WR,   26'h010, 16'h8001, '0);
    add_test(T_RD,   26'h000, '0, '0);
    add_test(T_RD,   26'h010, '0, '0);
    add_test(T_WR,   26'h020, 16'hffff, '0);
    add_test(T_WR,   26'h020, 16'h0ff0, '0);
    add_test(T_RD,   26'h020, '0, '0);
    // Fill lines 224, 225 and 231 of the broadcast region
    add_test(T_WR,   26'he00, 16'hffff, '0);
    add_test(T_WR,   26'he10, 16'hffff, '0);
    add_test(T_WR,   26'he70, 16'hffff, '0);
    add_test(T_BC,   '0, '0, mk_desc(4'd0, 8'd0, 7'h01, 4'hf, 32'd0));
    add_test(T_WRBC, 26'h030, 16'hffff, mk_desc(4'd0, 8'd0, 7'h06, 4'h5, 32'd0));
    add_test(T_WRBC, 26'h040, 16'hffff, mk_desc(4'd0, 8'd0, 7'h1f, 4'h8, 32'd0));
    add_test(T_BC,   '0, '0, mk_desc(4'd0, 8'd0, 7'h00, 4'h3, 32'd0));
    add_test(T_RD,   26'he00, '0, '0);
    add_test(T_RD,   26'he10, '0, '0);
    add_test(T_RD,   26'he70, '0, '0);
    add_test(T_RD,   26'h030, '0, '0);
    add_test(T_RD,   26'h040, '0, '0);
    add_test(T_DESC, '0, '0, mk_desc(4'd0, 8'h11, 7'h00, 4'h0, 32'hcafe_0001));
    add_test(T_DESC, '0, '0, mk_desc(4'd1, 8'h22, 7'h00, 4'h0, 32'hcafe_0002));
    add_test(T_DESC, '0, '0, mk_desc(4'd2, 8'h33, 7'h11, 4'hc, 32'hbeef_0003));
    add_test(T_DESC, '0, '0, mk_desc(4'd3, 8'h44, 7'h00, 4'h0, 32'hcafe_0004));
    add_test(T_DESC, '0, '0, mk_desc(4'd9, 8'h55, 7'h00, 4'h0, 32'hcafe_0005));
    add_test(T_DESC, '0, '0, mk_desc(4'd1, 8'h66, 7'h00, 4'h0, 32'hcafe_0006));
    add_test(T_STAT, '0, '0, '0);
    add_test(T_CRST, '0, '0, '0);
    add_test(T_STAT, '0, '0, '0);
    add_test(T_RD,   26'h000, '0, '0);
    add_test(T_RD,   26'he00, '0, '0);
    add_test(T_DESC, '0, '0, mk_desc(4'd0, 8'h77, 7'h00, 4'h0, 32'hcafe_0007));
    add_test(T_BC,   '0, '0, mk_desc(4'd0, 8'd0, 7'h02, 4'hf, 32'd0));
    add_test(T_RD,   26'he00, '0, '0);
    add_test(T_STAT, '0, '0, '0);
  endfunction

  initial begin
    void'($urandom(32'hcc8f));
    reset             = 1'b1;
    core_reset        = 1'b0;
    dma_wr            = '0;
    dma_wr_valid      = 1'b0;
    dma_rd            = '0;
    dma_rd_valid      = 1'b0;
    dma_rd_resp_ready = 1'b0;
    in_desc           = '0;
    in_desc_valid     = 1'b0;
    out_desc_ready    = 1'b0;
    bc_msg_in         = '0;
    bc_msg_in_valid   = 1'b0;
    bc_msg_out_ready  = 1'b0;
    wrapper_status    = '{addr: 3'd0, data: STATUS_WORD0};
    build_tests();
    limit = 40 * tests.size();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);
    for (int i = 0; i < tests.size(); i++) begin
      case (tests[i].kind)
        T_WR:    dma_write(tests[i], 1'b0);
        T_WRBC:  dma_write(tests[i], 1'b1);
        T_RD:    dma_read(tests[i].addr);
        T_BC:    send_bc(tests[i].desc);
        T_DESC:  send_desc(tests[i].desc);
        T_CRST:  pulse_core_reset();
        default: check_status();
      endcase
      repeat (4) @(posedge clk);
      $display("test %0d %s finished, errors so far %0d", i, tests[i].kind.name(), errors);
    end
    errors += i_dut.chk_inst.fail_cnt;
    $display("tests %0d checks %0d errors %0d", tests.size(), n_checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: pr_wrapper.f
+incdir+.
pr_pkg.sv
pipe_reg.sv
pkt_mem.sv
desc_engine.sv
status_unit.sv
pr_core.sv
pr_wrapper.sv
pr_wrapper_chk.sv
tb_pr_wrapper.sv
